// File: hdl/backplane_params.svh
// Shared constants of the backplane: bus widths, slave numbering, I/O page map
// and SD card idle levels. Include it in any file that needs one of these values.

`ifndef BACKPLANE_PARAMS_SVH
`define BACKPLANE_PARAMS_SVH

// ****************************************
// bus geometry
// ****************************************
`define BUS_W    16          // data and address width
`define N_SLAVE  9           // ram plus eight i/o page devices
`define N_DMA    2           // rk, my
`define N_SD     4           // rk, dw, dx, my

// slave strobe / ack / data index
`define SL_RAM    0
`define SL_UART1  1
`define SL_UART2  2
`define SL_RK     3
`define SL_LPT    4
`define SL_DW     5
`define SL_RX     6
`define SL_MY     7
`define SL_KGD    8

// ****************************************
// i/o page map, octal byte addresses
// ****************************************
// each *_MASK is the count of low address bits ignored by the compare
`define UART1_BASE  16'o177560   // console port
`define UART1_MASK  3
`define UART2_BASE  16'o176500   // second serial port
`define UART2_MASK  3
`define LPT_BASE    16'o177514   // printer
`define LPT_MASK    2
`define RK_BASE     16'o177400   // rk11 disk
`define RK_MASK     4
`define DW_BASE     16'o174000   // dw hard disk
`define DW_MASK     5
`define RX_BASE     16'o177170   // rx01 floppy
`define RX_MASK     2
`define MY_BASE     16'o172140   // my floppy
`define MY_MASK     2
`define KGD_BASE    16'o176640   // graphics
`define KGD_MASK    3

`define IO_PAGE     3'd7         // top three address bits of the i/o page

// sd card lines while no controller holds the card
`define SD_IDLE_MOSI  1'b1
`define SD_IDLE_CS    1'b1

`endif

// File: hdl/backplane_pkg.sv
// Bus types shared by the backplane modules.
// Ports name them as backplane_pkg::<type>, bodies import the package.

`default_nettype none

`include "backplane_params.svh"

package backplane_pkg;

   // one data word on the shared bus
   typedef logic [`BUS_W-1:0] bus_word_t;

   // bus address, seen as a flat byte address or split into page and offset
   typedef union packed {
      logic [`BUS_W-1:0] raw;       // full address, i/o base compares
      struct packed {
         logic [2:0]  page;         // 7 = i/o page
         logic [12:0] offset;       // byte within the 8k page
      } pg;
   } bus_addr_u;

endpackage

`default_nettype wire

// File: hdl/dma_arbiter.sv
// Bus master arbiter. Holds the registered DMA grants (RK over MY), steers the
// granted master onto the shared bus and returns the bus ack to that master only.
// The CPU owns the bus whenever no DMA grant is set.

`timescale 1ns/1ps
`default_nettype none

`include "backplane_params.svh"

module dma_arbiter (
   input  logic                   wb_clk,
   input  logic                   rst_i,
   // cpu side
   input  backplane_pkg::bus_addr_u cpu_adr_i,
   input  backplane_pkg::bus_word_t cpu_dat_i,
   input  logic                   cpu_cyc_i,
   input  logic                   cpu_stb_i,
   input  logic                   cpu_we_i,
   input  logic [1:0]             cpu_sel_i,
   output logic                   cpu_gnt_o,     // 0 while a dma master owns the bus
   output logic                   cpu_ack_o,
   // dma masters, index 0 = rk, 1 = my
   input  logic [`N_DMA-1:0]      dma_req_i,     // also the master's cyc
   input  backplane_pkg::bus_addr_u dma_adr_i [`N_DMA],
   input  backplane_pkg::bus_word_t dma_dat_i [`N_DMA],
   input  logic [`N_DMA-1:0]      dma_stb_i,
   input  logic [`N_DMA-1:0]      dma_we_i,
   output logic [`N_DMA-1:0]      dma_gnt_o,
   output logic [`N_DMA-1:0]      dma_ack_o,
   // shared bus
   input  logic                   bus_ack_i,     // ored slave acks
   output backplane_pkg::bus_addr_u bus_adr_o,
   output backplane_pkg::bus_word_t bus_dat_o,
   output logic                   bus_cyc_o,
   output logic                   bus_stb_o,
   output logic                   bus_we_o,
   output logic [1:0]             bus_sel_o
);

   logic [`N_DMA-1:0] gnt_q;     // one-hot or zero
   logic [`N_DMA-1:0] gnt_nxt;

   // ****************************************
   // grant register
   // ****************************************
   // fixed priority, lowest index wins
   always_comb begin
      gnt_nxt = '0;              // no request, bus back to cpu
      for (int k = `N_DMA-1; k >= 0; k--) begin
         if (dma_req_i[k]) begin
            gnt_nxt    = '0;
            gnt_nxt[k] = 1'b1;
         end
      end
   end

   // switch owner only between bus cycles
   always_ff @(posedge wb_clk) begin
      if (rst_i) begin
         gnt_q <= '0;
      end else if (!bus_cyc_o) begin
         gnt_q <= gnt_nxt;
      end
   end

   assign dma_gnt_o = gnt_q;
   assign cpu_gnt_o = ~|gnt_q;

   // ****************************************
   // master mux
   // ****************************************
   always_comb begin
      // cpu by default
      bus_adr_o = cpu_adr_i;
      bus_dat_o = cpu_dat_i;
      bus_cyc_o = cpu_cyc_i;
      bus_stb_o = cpu_stb_i;
      bus_we_o  = cpu_we_i;
      bus_sel_o = cpu_sel_i;
      for (int k = `N_DMA-1; k >= 0; k--) begin
         if (gnt_q[k]) begin
            bus_adr_o = dma_adr_i[k];
            bus_dat_o = dma_dat_i[k];
            bus_cyc_o = dma_req_i[k];   // cyc follows the request level
            bus_stb_o = dma_stb_i[k];
            bus_we_o  = dma_we_i[k];
            bus_sel_o = 2'b11;          // dma moves whole words
         end
      end
   end

   // ack goes back to the owner only, others keep waiting
   assign cpu_ack_o = cpu_gnt_o & bus_ack_i;
   assign dma_ack_o = gnt_q & {`N_DMA{bus_ack_i}};

endmodule

`default_nettype wire

// File: hdl/io_decoder.sv
// Address decoder of the shared bus. Turns the bus address, cyc and stb into
// one strobe per slave: main memory below the I/O page, one strobe per device
// register block inside it. sysram_stb_i forces the memory strobe.

`timescale 1ns/1ps
`default_nettype none

`include "backplane_params.svh"

module io_decoder (
   input  backplane_pkg::bus_addr_u bus_adr_i,
   input  logic                   bus_cyc_i,
   input  logic                   bus_stb_i,
   input  logic                   sysram_stb_i,  // cpu board service memory
   output logic [`N_SLAVE-1:0]    dev_stb_o
);

   logic act;                    // a bus access is in progress

   // address hit, low ign bits don't care
   function automatic logic io_hit(
      input logic [`BUS_W-1:0] adr,
      input logic [`BUS_W-1:0] base,
      input int                ign
   );
      return (adr >> ign) == (base >> ign);
   endfunction

   assign act = bus_cyc_i & bus_stb_i;

   // ****************************************
   // main memory
   // ****************************************
   // 000000-157776, plus the service area on request
   assign dev_stb_o[`SL_RAM] = (act & (bus_adr_i.pg.page != `IO_PAGE)) | sysram_stb_i;

   // ****************************************
   // i/o page devices
   // ****************************************
   assign dev_stb_o[`SL_UART1] = act & io_hit(bus_adr_i.raw, `UART1_BASE, `UART1_MASK);
   assign dev_stb_o[`SL_UART2] = act & io_hit(bus_adr_i.raw, `UART2_BASE, `UART2_MASK);
   assign dev_stb_o[`SL_RK]    = act & io_hit(bus_adr_i.raw, `RK_BASE, `RK_MASK);
   assign dev_stb_o[`SL_LPT]   = act & io_hit(bus_adr_i.raw, `LPT_BASE, `LPT_MASK);
   assign dev_stb_o[`SL_DW]    = act & io_hit(bus_adr_i.raw, `DW_BASE, `DW_MASK);
   assign dev_stb_o[`SL_RX]    = act & io_hit(bus_adr_i.raw, `RX_BASE, `RX_MASK);
   assign dev_stb_o[`SL_MY]    = act & io_hit(bus_adr_i.raw, `MY_BASE, `MY_MASK);
   assign dev_stb_o[`SL_KGD]   = act & io_hit(bus_adr_i.raw, `KGD_BASE, `KGD_MASK);

endmodule

`default_nettype wire

// File: hdl/slave_response.sv
// Collects the slave responses for the bus master: acks are ored together,
// read data is taken from whichever slave is strobed. Slaves not strobed
// contribute zero, so an idle bus reads as zero.

`timescale 1ns/1ps
`default_nettype none

`include "backplane_params.svh"

module slave_response (
   input  logic [`N_SLAVE-1:0]      dev_stb_i,   // from the decoder
   input  logic [`N_SLAVE-1:0]      dev_ack_i,
   input  backplane_pkg::bus_word_t dev_dat_i [`N_SLAVE],
   output logic                     bus_ack_o,
   output backplane_pkg::bus_word_t bus_dat_o
);

   import backplane_pkg::*;

   // ****************************************
   // ack collection
   // ****************************************
   // a slave acks only its own strobe
   assign bus_ack_o = |dev_ack_i;

   // ****************************************
   // read data mux
   // ****************************************
   always_comb begin
      bus_word_t acc;            // running or of gated words

      acc = '0;
      for (int s = 0; s < `N_SLAVE; s++) begin
         if (dev_stb_i[s]) begin
            acc = acc | dev_dat_i[s];
         end
      end
      bus_dat_o = acc;
   end

endmodule

`default_nettype wire

// File: hdl/sdcard_dispatcher.sv
// SD card dispatcher. The single card is lent to one disk controller at a
// time on a level request/ack handshake, and its MOSI and CS come from the
// holder. Controller order is RK, DW, DX, MY.

`timescale 1ns/1ps
`default_nettype none

`include "backplane_params.svh"

module sdcard_dispatcher (
   input  logic              wb_clk,
   input  logic              rst_i,
   input  logic [`N_SD-1:0]  sd_req_i,     // held for the whole card session
   input  logic [`N_SD-1:0]  sd_mosi_i,
   input  logic [`N_SD-1:0]  sd_cs_i,
   output logic [`N_SD-1:0]  sd_ack_o,     // at most one high
   output logic              sdcard_mosi_o,
   output logic              sdcard_cs_o
);

   localparam int SD_RK = 0;
   localparam int SD_DW = 1;
   localparam int SD_DX = 2;
   localparam int SD_MY = 3;

   logic [`N_SD-1:0] ack_q;
   logic [`N_SD-1:0] ack_nxt;

   // ****************************************
   // grant / release
   // ****************************************
   always_comb begin
      ack_nxt = ack_q;
      if (ack_q == '0) begin
         // idle, first requester in rk..my order takes the card
         for (int k = `N_SD-1; k >= 0; k--) begin
            if (sd_req_i[k]) begin
               ack_nxt    = '0;
               ack_nxt[k] = 1'b1;
            end
         end
      end else begin
         // busy, wait for the holder to drop its request
         for (int k = `N_SD-1; k >= 0; k--) begin
            if (ack_q[k] && !sd_req_i[k]) begin
               ack_nxt    = ack_q;
               ack_nxt[k] = 1'b0;   // one release per edge
            end
         end
      end
   end

   // a release always passes through the idle state, never straight to another
   always_ff @(posedge wb_clk) begin
      if (rst_i) begin
         ack_q <= '0;
      end else begin
         ack_q <= ack_nxt;
      end
   end

   assign sd_ack_o = ack_q;

   // ****************************************
   // card line mux
   // ****************************************
   always_comb begin
      sdcard_mosi_o = `SD_IDLE_MOSI;        // nobody holds the card
      sdcard_cs_o   = `SD_IDLE_CS;
      // later checks win, so dw > dx > my > rk
      if (ack_q[SD_RK]) begin
         sdcard_mosi_o = sd_mosi_i[SD_RK];
         sdcard_cs_o   = sd_cs_i[SD_RK];
      end
      if (ack_q[SD_MY]) begin
         sdcard_mosi_o = sd_mosi_i[SD_MY];
         sdcard_cs_o   = sd_cs_i[SD_MY];
      end
      if (ack_q[SD_DX]) begin
         sdcard_mosi_o = sd_mosi_i[SD_DX];
         sdcard_cs_o   = sd_cs_i[SD_DX];
      end
      if (ack_q[SD_DW]) begin
         sdcard_mosi_o = sd_mosi_i[SD_DW];
         sdcard_cs_o   = sd_cs_i[SD_DW];
      end
   end

endmodule

`default_nettype wire

// File: hdl/backplane.sv
// Backplane top level. Chains the master arbiter, address decoder and slave
// response collector on one shared bus, next to the SD card dispatcher.
// CPU, DMA controllers and all slaves sit outside and connect here.

`timescale 1ns/1ps
`default_nettype none

`include "backplane_params.svh"

module backplane (
   input  logic                     wb_clk,
   input  logic                     rst_i,
   // cpu master
   input  backplane_pkg::bus_addr_u cpu_adr_i,
   input  backplane_pkg::bus_word_t cpu_dat_i,
   input  logic                     cpu_cyc_i,
   input  logic                     cpu_stb_i,
   input  logic                     cpu_we_i,
   input  logic [1:0]               cpu_sel_i,
   input  logic                     sysram_stb_i,
   output logic                     cpu_gnt_o,
   output logic                     cpu_ack_o,
   // dma masters, 0 = rk, 1 = my
   input  logic [`N_DMA-1:0]        dma_req_i,
   input  backplane_pkg::bus_addr_u dma_adr_i [`N_DMA],
   input  backplane_pkg::bus_word_t dma_dat_i [`N_DMA],
   input  logic [`N_DMA-1:0]        dma_stb_i,
   input  logic [`N_DMA-1:0]        dma_we_i,
   output logic [`N_DMA-1:0]        dma_gnt_o,
   output logic [`N_DMA-1:0]        dma_ack_o,
   // shared bus toward the slaves
   output backplane_pkg::bus_addr_u bus_adr_o,
   output backplane_pkg::bus_word_t bus_dat_w_o,  // write data
   output logic                     bus_cyc_o,
   output logic                     bus_stb_o,
   output logic                     bus_we_o,
   output logic [1:0]               bus_sel_o,
   output logic [`N_SLAVE-1:0]      dev_stb_o,
   input  logic [`N_SLAVE-1:0]      dev_ack_i,
   input  backplane_pkg::bus_word_t dev_dat_i [`N_SLAVE],
   output backplane_pkg::bus_word_t bus_dat_o,    // read data, all masters
   // sd card sharing, rk dw dx my
   input  logic [`N_SD-1:0]         sd_req_i,
   input  logic [`N_SD-1:0]         sd_mosi_i,
   input  logic [`N_SD-1:0]         sd_cs_i,
   output logic [`N_SD-1:0]         sd_ack_o,
   output logic                     sdcard_mosi_o,
   output logic                     sdcard_cs_o
);

   logic bus_ack;                // ored slave acks, back to the arbiter

   // ****************************************
   // bus path
   // ****************************************
   dma_arbiter u_arb (
      .wb_clk     (wb_clk),
      .rst_i      (rst_i),
      .cpu_adr_i  (cpu_adr_i),
      .cpu_dat_i  (cpu_dat_i),
      .cpu_cyc_i  (cpu_cyc_i),
      .cpu_stb_i  (cpu_stb_i),
      .cpu_we_i   (cpu_we_i),
      .cpu_sel_i  (cpu_sel_i),
      .cpu_gnt_o  (cpu_gnt_o),
      .cpu_ack_o  (cpu_ack_o),
      .dma_req_i  (dma_req_i),
      .dma_adr_i  (dma_adr_i),
      .dma_dat_i  (dma_dat_i),
      .dma_stb_i  (dma_stb_i),
      .dma_we_i   (dma_we_i),
      .dma_gnt_o  (dma_gnt_o),
      .dma_ack_o  (dma_ack_o),
      .bus_ack_i  (bus_ack),
      .bus_adr_o  (bus_adr_o),
      .bus_dat_o  (bus_dat_w_o),
      .bus_cyc_o  (bus_cyc_o),
      .bus_stb_o  (bus_stb_o),
      .bus_we_o   (bus_we_o),
      .bus_sel_o  (bus_sel_o)
   );

   io_decoder u_dec (
      .bus_adr_i    (bus_adr_o),
      .bus_cyc_i    (bus_cyc_o),
      .bus_stb_i    (bus_stb_o),
      .sysram_stb_i (sysram_stb_i),
      .dev_stb_o    (dev_stb_o)
   );

   slave_response u_rsp (
      .dev_stb_i  (dev_stb_o),
      .dev_ack_i  (dev_ack_i),
      .dev_dat_i  (dev_dat_i),
      .bus_ack_o  (bus_ack),
      .bus_dat_o  (bus_dat_o)
   );

   // ****************************************
   // sd card
   // ****************************************
   sdcard_dispatcher u_sd (
      .wb_clk        (wb_clk),
      .rst_i         (rst_i),
      .sd_req_i      (sd_req_i),
      .sd_mosi_i     (sd_mosi_i),
      .sd_cs_i       (sd_cs_i),
      .sd_ack_o      (sd_ack_o),
      .sdcard_mosi_o (sdcard_mosi_o),
      .sdcard_cs_o   (sdcard_cs_o)
   );

endmodule

`default_nettype wire

// File: tb/backplane_chk.sv
// Concurrent checks on registered owner state. One copy watches the DMA grants
// of the arbiter, another the SD card acks of the dispatcher.

`timescale 1ns/1ps
`default_nettype none

`include "backplane_params.svh"

module backplane_chk #(
   parameter int W        = 2,
   parameter bit VIA_IDLE = 1'b0     // owner change has to pass through zero
) (
   input  logic         wb_clk,
   input  logic         rst_i,
   input  logic [W-1:0] own_i,       // grant or ack vector
   input  logic         hold_i       // owner frozen on this edge
);

   int n_fail = 0;                   // failed assertions, read by the testbench

   // at most one owner
   a_one_hot: assert property (@(posedge wb_clk) disable iff (rst_i) $onehot0(own_i))
      else begin
         n_fail++;
         $error("owner vector not one-hot: %b", own_i);
      end

   // no switch while the owner is held
   a_hold: assert property (@(posedge wb_clk) disable iff (rst_i) hold_i |=> $stable(own_i))
      else begin
         n_fail++;
         $error("owner changed on an edge where it was held");
      end

   // holder -> idle -> next holder
   a_via_idle: assert property (@(posedge wb_clk) disable iff (rst_i)
      (VIA_IDLE && own_i != '0) |=> (own_i == '0 || $stable(own_i)))
      else begin
         n_fail++;
         $error("owner moved straight to another user");
      end

endmodule

bind dma_arbiter backplane_chk #(.W(`N_DMA), .VIA_IDLE(1'b0)) u_chk (
   .wb_clk (wb_clk),
   .rst_i  (rst_i),
   .own_i  (gnt_q),
   .hold_i (bus_cyc_o)
);

// card stays with the holder while its request is up
bind sdcard_dispatcher backplane_chk #(.W(`N_SD), .VIA_IDLE(1'b1)) u_chk (
   .wb_clk (wb_clk),
   .rst_i  (rst_i),
   .own_i  (ack_q),
   .hold_i (|(ack_q & sd_req_i))
);

`default_nettype wire

// File: tb/backplane_tb.sv
// Testbench of the backplane. Random CPU, DMA, slave and SD card traffic from a
// fixed seed, compared every cycle against a reference model kept here.

`timescale 1ns/1ps
`default_nettype none

`include "backplane_params.svh"

module backplane_tb;

   import backplane_pkg::*;

   localparam int N_CYC = 3000;     // random cycles

   logic                wb_clk = 1'b0;
   logic                rst_i;
   bus_addr_u           cpu_adr_i;
   bus_word_t           cpu_dat_i;
   logic                cpu_cyc_i, cpu_stb_i, cpu_we_i, sysram_stb_i;
   logic [1:0]          cpu_sel_i;
   logic                cpu_gnt_o, cpu_ack_o;
   logic [`N_DMA-1:0]   dma_req_i, dma_stb_i, dma_we_i, dma_gnt_o, dma_ack_o;
   bus_addr_u           dma_adr_i [`N_DMA];
   bus_word_t           dma_dat_i [`N_DMA];
   bus_addr_u           bus_adr_o;
   bus_word_t           bus_dat_w_o, bus_dat_o;
   logic                bus_cyc_o, bus_stb_o, bus_we_o;
   logic [1:0]          bus_sel_o;
   logic [`N_SLAVE-1:0] dev_stb_o, dev_ack_i;
   bus_word_t           dev_dat_i [`N_SLAVE];
   logic [`N_SD-1:0]    sd_req_i, sd_mosi_i, sd_cs_i, sd_ack_o;
   logic                sdcard_mosi_o, sdcard_cs_o;

   // reference model state
   logic [`N_DMA-1:0]   gnt_m;            // dma grants
   logic [`N_SD-1:0]    sd_ack_m;         // sd card holder
   logic [3:0]          dma_len [`N_DMA]; // cycles left after grant
   logic [3:0]          sd_len [`N_SD];
   integer              seed;
   int                  errors;
   int                  checks;

   backplane UUT (.*);

   always #2 wb_clk = ~wb_clk;           // 4 ns period

   // ****************************************
   // helpers
   // ****************************************
   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("mismatch at %t: %s expected %0h got %0h", $time, name, exp, act);
      end
   endtask

   function automatic logic [15:0] slave_base(input int s);
      case (s)
         `SL_UART1: return `UART1_BASE;
         `SL_UART2: return `UART2_BASE;
         `SL_RK:    return `RK_BASE;
         `SL_LPT:   return `LPT_BASE;
         `SL_DW:    return `DW_BASE;
         `SL_RX:    return `RX_BASE;
         `SL_MY:    return `MY_BASE;
         `SL_KGD:   return `KGD_BASE;
         default:   return 16'h0000;
      endcase
   endfunction

   function automatic int slave_ign(input int s);   // low bits left out of the compare
      case (s)
         `SL_UART1: return `UART1_MASK;
         `SL_UART2: return `UART2_MASK;
         `SL_RK:    return `RK_MASK;
         `SL_LPT:   return `LPT_MASK;
         `SL_DW:    return `DW_MASK;
         `SL_RX:    return `RX_MASK;
         `SL_MY:    return `MY_MASK;
         `SL_KGD:   return `KGD_MASK;
         default:   return 0;
      endcase
   endfunction

   // address biased to ram, to the device windows and around them
   function automatic logic [15:0] pick_adr(input logic [31:0] r);
      int s;
      s = 32'(r[6:4]) + 1;                  // slave 1..8
      if (r[1:0] == 2'd0)
         return {(r[18:16] == 3'd7) ? 3'd0 : r[18:16], r[31:19]};
      else if (r[1:0] == 2'd3)
         return {3'b111, r[28:16]};         // anywhere in the i/o page
      else                                  // half in the window, half past it
         return slave_base(s) + (r[31:16] & ((16'd2 << slave_ign(s)) - 16'd1));
   endfunction

   function automatic logic [`N_SLAVE-1:0] expect_stb(input logic [15:0] adr,
         input logic cyc, input logic stb, input logic sysram);
      logic [`N_SLAVE-1:0] s;
      logic [15:0]         keep;
      int                  i;
      s = '0;
      if (cyc && stb) begin
         s[`SL_RAM] = (adr[15:13] != 3'b111);
         for (i = 1; i < `N_SLAVE; i++) begin
            keep = 16'hffff << slave_ign(i);
            s[i] = ((adr & keep) == (slave_base(i) & keep));
         end
      end
      if (sysram) s[`SL_RAM] = 1'b1;        // service memory overrides
      return s;
   endfunction

   // ****************************************
   // model, stimulus, compare
   // ****************************************
   task automatic update_models();          // one clock edge, inputs before it
      logic cyc_m;
      logic found;
      int   k;
      cyc_m = gnt_m[0] ? dma_req_i[0] : (gnt_m[1] ? dma_req_i[1] : cpu_cyc_i);
      if (!cyc_m)                           // owner moves only between cycles
         gnt_m = dma_req_i[0] ? 2'b01 : (dma_req_i[1] ? 2'b10 : 2'b00);
      found = 1'b0;
      for (k = 0; k < `N_SD; k++) begin
         if (sd_ack_m == 4'b0000 && !found && sd_req_i[k]) begin
            sd_ack_m[k] = 1'b1;             // rk, dw, dx, my order
            found = 1'b1;
         end else if (sd_ack_m[k] && !sd_req_i[k] && !found) begin
            sd_ack_m[k] = 1'b0;
            found = 1'b1;
         end
      end
   endtask

   task automatic drive_random();
      logic [31:0] r;
      int          k;
      r = $random(seed);
      cpu_cyc_i    <= r[0];
      cpu_stb_i    <= r[1];
      cpu_we_i     <= r[2];
      cpu_sel_i    <= r[4:3];
      sysram_stb_i <= (r[7:5] == 3'd0);
      cpu_dat_i    <= r[31:16];
      cpu_adr_i.raw <= pick_adr($random(seed));
      r = $random(seed);
      dev_ack_i    <= r[8:0];
      for (k = 0; k < `N_SLAVE; k++) begin
         r = $random(seed);
         dev_dat_i[k] <= r[15:0];
      end
      for (k = 0; k < `N_DMA; k++) begin
         r = $random(seed);
         if (!dma_req_i[k]) begin
            if (r[2:0] == 3'd0) begin
               dma_req_i[k] <= 1'b1;
               dma_len[k] = r[6:3];
            end
         end else if (gnt_m[k]) begin       // count only while owning the bus
            if (dma_len[k] == 4'd0) dma_req_i[k] <= 1'b0;
            else dma_len[k] = dma_len[k] - 4'd1;
         end
         dma_stb_i[k] <= r[7];
         dma_we_i[k]  <= r[8];
         dma_dat_i[k] <= r[31:16];
         dma_adr_i[k].raw <= pick_adr($random(seed));
      end
      for (k = 0; k < `N_SD; k++) begin
         r = $random(seed);
         if (!sd_req_i[k]) begin
            if (r[1:0] == 2'd0) begin
               sd_req_i[k] <= 1'b1;
               sd_len[k] = r[5:2];
            end
         end else if (sd_ack_m[k]) begin    // holder keeps the card a while
            if (sd_len[k] == 4'd0) sd_req_i[k] <= 1'b0;
            else sd_len[k] = sd_len[k] - 4'd1;
         end
         sd_mosi_i[k] <= r[6];
         sd_cs_i[k]   <= r[7];
      end
   endtask

   task automatic check_outputs();
      logic [15:0]         adr, dat, rd;
      logic                cyc, stb, we, mosi, cs;
      logic [1:0]          sel;
      logic [`N_SLAVE-1:0] stb_m;
      int                  k;
      adr = cpu_adr_i.raw;                  // cpu unless a dma grant is set
      dat = cpu_dat_i;
      cyc = cpu_cyc_i;
      stb = cpu_stb_i;
      we  = cpu_we_i;
      sel = cpu_sel_i;
      for (k = 0; k < `N_DMA; k++) begin
         if (gnt_m[k]) begin
            adr = dma_adr_i[k].raw;
            dat = dma_dat_i[k];
            cyc = dma_req_i[k];
            stb = dma_stb_i[k];
            we  = dma_we_i[k];
            sel = 2'b11;
         end
      end
      stb_m = expect_stb(adr, cyc, stb, sysram_stb_i);
      rd = 16'h0000;
      for (k = 0; k < `N_SLAVE; k++)
         if (stb_m[k]) rd = rd | dev_dat_i[k];
      mosi = `SD_IDLE_MOSI;
      cs   = `SD_IDLE_CS;
      for (k = 0; k < `N_SD; k++) begin
         if (sd_ack_m[k]) begin
            mosi = sd_mosi_i[k];
            cs   = sd_cs_i[k];
         end
      end
      check_value("dma_gnt_o", 32'(gnt_m), 32'(dma_gnt_o));
      check_value("cpu_gnt_o", 32'(gnt_m == 2'b00), 32'(cpu_gnt_o));
      check_value("bus_adr_o", 32'(adr), 32'(bus_adr_o.raw));
      check_value("bus_dat_w_o", 32'(dat), 32'(bus_dat_w_o));
      check_value("bus_cyc_o", 32'(cyc), 32'(bus_cyc_o));
      check_value("bus_stb_o", 32'(stb), 32'(bus_stb_o));
      check_value("bus_we_o", 32'(we), 32'(bus_we_o));
      check_value("bus_sel_o", 32'(sel), 32'(bus_sel_o));
      check_value("dev_stb_o", 32'(stb_m), 32'(dev_stb_o));
      check_value("bus_dat_o", 32'(rd), 32'(bus_dat_o));
      check_value("cpu_ack_o", 32'((gnt_m == 2'b00) & (|dev_ack_i)), 32'(cpu_ack_o));
      check_value("dma_ack_o", 32'(gnt_m & {`N_DMA{|dev_ack_i}}), 32'(dma_ack_o));
      check_value("sd_ack_o", 32'(sd_ack_m), 32'(sd_ack_o));
      check_value("sdcard_mosi_o", 32'(mosi), 32'(sdcard_mosi_o));
      check_value("sdcard_cs_o", 32'(cs), 32'(sdcard_cs_o));
   endtask

   task automatic wait_bus_idle(input int limit);
      int n;
      n = 0;
      while ((dma_gnt_o !== 2'b00 || sd_ack_o !== 4'b0000) && n < limit) begin
         @(negedge wb_clk);
         n++;
      end
      if (dma_gnt_o !== 2'b00 || sd_ack_o !== 4'b0000) begin
         errors++;
         $display("timeout: grants or SD acks still set after all requests were dropped");
      end
   endtask

   // ****************************************
   // main sequence
   // ****************************************
   initial begin
      int k;
      $timeformat(-9, 0, " ns", 0);
      seed = 22011;
      errors = 0;
      checks = 0;
      gnt_m = '0;
      sd_ack_m = '0;
      rst_i = 1'b1;
      cpu_adr_i = '0;
      cpu_dat_i = '0;
      {cpu_cyc_i, cpu_stb_i, cpu_we_i, sysram_stb_i} = 4'b0000;
      cpu_sel_i = 2'b00;
      {dma_req_i, dma_stb_i, dma_we_i} = '0;
      {sd_req_i, sd_mosi_i, sd_cs_i} = '0;
      dev_ack_i = '0;
      for (k = 0; k < `N_DMA; k++) begin
         dma_adr_i[k] = '0;
         dma_dat_i[k] = '0;
         dma_len[k] = 4'd0;
      end
      for (k = 0; k < `N_SLAVE; k++) dev_dat_i[k] = '0;
      for (k = 0; k < `N_SD; k++) sd_len[k] = 4'd0;

      repeat (2) @(posedge wb_clk);
      rst_i <= 1'b0;
      @(negedge wb_clk);
      check_value("dma_gnt_o", 32'd0, 32'(dma_gnt_o));     // state right after reset
      check_value("sd_ack_o", 32'd0, 32'(sd_ack_o));
      check_value("cpu_gnt_o", 32'd1, 32'(cpu_gnt_o));

      repeat (N_CYC) begin
         @(posedge wb_clk);
         update_models();
         drive_random();
         @(negedge wb_clk);                 // combinational outputs settled
         check_outputs();
      end

      @(posedge wb_clk);
      cpu_cyc_i <= 1'b0;                    // everyone lets go
      dma_req_i <= '0;
      sd_req_i  <= '0;
      @(negedge wb_clk);
      wait_bus_idle(50);
      check_value("cpu_gnt_o", 32'd1, 32'(cpu_gnt_o));

      // failed bound assertions count as errors too
      errors += UUT.u_arb.u_chk.n_fail;
      errors += UUT.u_sd.u_chk.n_fail;

      $display("checks: %0d  errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sim.f
+incdir+hdl
hdl/backplane_pkg.sv
hdl/dma_arbiter.sv
hdl/io_decoder.sv
hdl/slave_response.sv
hdl/sdcard_dispatcher.sv
hdl/backplane.sv
tb/backplane_chk.sv
tb/backplane_tb.sv

// File: Makefile
# Verilator simulation of the backplane testbench

TOP := backplane_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, pass if the log holds the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   this list"

test:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
